/* signal_recovery_top.f */
src/axil_pkg.sv
src/recovery_pkg.sv
src/sample_fifo.sv
src/majority_recovery.sv
src/axil_reg_slave.sv
src/signal_recovery_top.sv
bench/signal_recovery_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f signal_recovery_top.f \
		--top-module signal_recovery_tb -o signal_recovery_sim
	./obj_dir/signal_recovery_sim > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/signal_recovery_tb.sv */
// Directed testbench for the recovery block that drives AXI4-Lite transfers and checks registers
module signal_recovery_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int depth = recovery_pkg::default_depth;
    localparam int timeout_cycles = 50;
    localparam int max_polls = 40;

    logic                 clk_buf2;
    logic                 rst_n_buf1;
    axil_pkg::axil_aw_t   aw;
    logic                 awvalid;
    logic                 awready;
    axil_pkg::axil_w_t    w;
    logic                 wvalid;
    logic                 wready;
    axil_pkg::axil_resp_t bresp;
    logic                 bvalid;
    logic                 bready;
    axil_pkg::axil_ar_t   ar;
    logic                 arvalid;
    logic                 arready;
    axil_pkg::axil_r_t    r;
    logic                 rvalid;
    logic                 rready;

    int          seed;
    logic [7:0]  model_hist [3];
    logic [15:0] model_count;

    signal_recovery_top #(
        .depth (depth)
    ) i_signal_recovery_top (
        .clk_buf2   (clk_buf2),
        .rst_n_buf1 (rst_n_buf1),
        .aw         (aw),
        .awvalid    (awvalid),
        .awready    (awready),
        .w          (w),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .ar         (ar),
        .arvalid    (arvalid),
        .arready    (arready),
        .r          (r),
        .rvalid     (rvalid),
        .rready     (rready)
    );

    initial begin
        clk_buf2 = 1'b0;
        forever #5 clk_buf2 = ~clk_buf2;
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic expect_equal(input string test_name, input string what,
                                input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s: %s expected 0x%08h actual 0x%08h", test_name, what,
                     expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_resp(input string test_name, input string what,
                                input axil_pkg::axil_resp_t expected,
                                input axil_pkg::axil_resp_t actual);
        expect_equal(test_name, what, {30'd0, expected}, {30'd0, actual});
    endtask

    // Both channels are raised together; bready is held until the response edge
    task automatic axil_write(input logic [4:0] offset, input logic [31:0] data,
                              input logic [3:0] strb, output axil_pkg::axil_resp_t resp);
        int cycles;
        @(posedge clk_buf2);
        aw.addr <= {27'd0, offset};
        aw.prot <= 3'b000;
        w.data  <= data;
        w.strb  <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk_buf2);
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("Timeout: no awready and wready for write to offset 0x%02h", offset);
                abort_run();
            end
        end while (!(awready && wready));
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        cycles = 0;
        while (!bvalid) begin
            @(posedge clk_buf2);
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("Timeout: no write response for offset 0x%02h", offset);
                abort_run();
            end
        end
        resp = bresp;
        bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [4:0] offset, output logic [31:0] data,
                             output axil_pkg::axil_resp_t resp);
        int cycles;
        @(posedge clk_buf2);
        ar.addr <= {27'd0, offset};
        ar.prot <= 3'b000;
        arvalid <= 1'b1;
        rready  <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk_buf2);
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("Timeout: no arready for read of offset 0x%02h", offset);
                abort_run();
            end
        end while (!arready);
        arvalid <= 1'b0;
        cycles = 0;
        while (!rvalid) begin
            @(posedge clk_buf2);
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("Timeout: no read data for offset 0x%02h", offset);
                abort_run();
            end
        end
        data = r.data;
        resp = r.resp;
        rready <= 1'b0;
    endtask

    // Two or more ones out of three per bit
    function automatic logic [7:0] majority_of(input logic [7:0] a, input logic [7:0] b,
                                               input logic [7:0] c);
        logic [7:0] vote;
        int         ones;
        for (int i = 0; i < 8; i++) begin
            ones = int'(a[i]) + int'(b[i]) + int'(c[i]);
            vote[i] = (ones >= 2);
        end
        return vote;
    endfunction

    task automatic model_accept(input logic [7:0] value, input logic restart);
        if (restart) begin
            model_hist[2] = value;
            model_hist[1] = value;
        end else begin
            model_hist[2] = model_hist[1];
            model_hist[1] = model_hist[0];
        end
        model_hist[0] = value;
        model_count++;
    endtask

    // Poll STATUS for empty and COUNT for the expected total
    task automatic wait_drained(input string test_name, input logic [15:0] exp_count);
        logic [31:0]          data;
        axil_pkg::axil_resp_t resp;
        int                   polls;
        bit                   done;
        polls = 0;
        done = 1'b0;
        while (!done) begin
            axil_read(recovery_pkg::addr_status, data, resp);
            if (data[9]) begin
                axil_read(recovery_pkg::addr_count, data, resp);
                done = (data[15:0] == exp_count);
            end
            polls++;
            if (!done && polls > max_polls) begin
                $display("Timeout: %s never drained to count %0d", test_name, exp_count);
                abort_run();
            end
        end
    endtask

    task automatic check_results(input string test_name);
        logic [31:0]          data;
        axil_pkg::axil_resp_t resp;
        axil_read(recovery_pkg::addr_clean, data, resp);
        compare_resp(test_name, "clean resp", axil_pkg::resp_okay, resp);
        expect_equal(test_name, "clean",
                     {24'd0, majority_of(model_hist[0], model_hist[1], model_hist[2])}, data);
        axil_read(recovery_pkg::addr_count, data, resp);
        compare_resp(test_name, "count resp", axil_pkg::resp_okay, resp);
        expect_equal(test_name, "count", {16'd0, model_count}, data);
    endtask

    task automatic verify_reset_state();
        logic [31:0]          data;
        axil_pkg::axil_resp_t resp;
        axil_read(recovery_pkg::addr_control, data, resp);
        compare_resp("reset_state", "control resp", axil_pkg::resp_okay, resp);
        expect_equal("reset_state", "control", 32'd0, data);
        axil_read(recovery_pkg::addr_status, data, resp);
        compare_resp("reset_state", "status resp", axil_pkg::resp_okay, resp);
        expect_equal("reset_state", "status", 32'h0000_0200, data);
        axil_read(recovery_pkg::addr_sample, data, resp);
        compare_resp("reset_state", "sample resp", axil_pkg::resp_okay, resp);
        expect_equal("reset_state", "sample", 32'd0, data);
        check_results("reset_state");
    endtask

    task automatic run_restart_sample();
        axil_pkg::axil_resp_t resp;
        axil_write(recovery_pkg::addr_sample, 32'h0000_01A5, 4'b0011, resp);
        compare_resp("restart_sample", "write resp", axil_pkg::resp_okay, resp);
        model_accept(8'hA5, 1'b1);
        wait_drained("restart_sample", model_count);
        check_results("restart_sample");
    endtask

    task automatic stream_majority_values();
        axil_pkg::axil_resp_t resp;
        int                   rnd;
        logic [7:0]           value;
        for (int n = 0; n < 20; n++) begin
            rnd = $random(seed);
            value = rnd[7:0];
            axil_write(recovery_pkg::addr_sample, {24'd0, value}, 4'b0001, resp);
            compare_resp("majority_stream", "write resp", axil_pkg::resp_okay, resp);
            model_accept(value, 1'b0);
            wait_drained("majority_stream", model_count);
            check_results("majority_stream");
        end
    endtask

    task automatic fill_and_overflow();
        axil_pkg::axil_resp_t resp;
        logic [31:0]          data;
        logic [31:0]          exp_status;
        int                   rnd;
        logic [7:0]           value;
        axil_write(recovery_pkg::addr_control, 32'd1, 4'b0001, resp);
        compare_resp("buffer_overflow", "pause resp", axil_pkg::resp_okay, resp);
        for (int n = 0; n < depth; n++) begin
            rnd = $random(seed);
            value = rnd[7:0];
            axil_write(recovery_pkg::addr_sample, {24'd0, value}, 4'b0001, resp);
            compare_resp("buffer_overflow", "buffered write resp", axil_pkg::resp_okay, resp);
            model_accept(value, 1'b0);
        end
        exp_status = 32'd0;
        exp_status[8] = 1'b1;
        exp_status[7:0] = 8'(depth);
        axil_read(recovery_pkg::addr_status, data, resp);
        expect_equal("buffer_overflow", "status when full", exp_status, data);
        // Refused sample never reaches the model
        axil_write(recovery_pkg::addr_sample, 32'h0000_005A, 4'b0001, resp);
        compare_resp("buffer_overflow", "overflow resp", axil_pkg::resp_slverr, resp);
        axil_write(recovery_pkg::addr_control, 32'd0, 4'b0001, resp);
        compare_resp("buffer_overflow", "resume resp", axil_pkg::resp_okay, resp);
        wait_drained("buffer_overflow", model_count);
        check_results("buffer_overflow");
    endtask

    task automatic probe_decode_errors();
        axil_pkg::axil_resp_t resp;
        logic [31:0]          data;
        axil_write(recovery_pkg::addr_clean, 32'hFFFF_FFFF, 4'hF, resp);
        compare_resp("decode_errors", "clean write resp", axil_pkg::resp_slverr, resp);
        axil_write(recovery_pkg::addr_status, 32'hFFFF_FFFF, 4'hF, resp);
        compare_resp("decode_errors", "status write resp", axil_pkg::resp_slverr, resp);
        axil_write(recovery_pkg::addr_count, 32'hFFFF_FFFF, 4'hF, resp);
        compare_resp("decode_errors", "count write resp", axil_pkg::resp_slverr, resp);
        axil_write(5'h14, 32'hFFFF_FFFF, 4'hF, resp);
        compare_resp("decode_errors", "unmapped write resp", axil_pkg::resp_slverr, resp);
        axil_read(5'h14, data, resp);
        compare_resp("decode_errors", "unmapped read resp", axil_pkg::resp_slverr, resp);
        expect_equal("decode_errors", "unmapped read data", 32'd0, data);
        axil_write(recovery_pkg::addr_control, 32'd1, 4'b0001, resp);
        compare_resp("decode_errors", "control write resp", axil_pkg::resp_okay, resp);
        axil_read(recovery_pkg::addr_control, data, resp);
        expect_equal("decode_errors", "control read-back", 32'd1, data);
        axil_write(recovery_pkg::addr_control, 32'd0, 4'b0001, resp);
        axil_read(recovery_pkg::addr_control, data, resp);
        expect_equal("decode_errors", "control cleared", 32'd0, data);
        check_results("decode_errors");
    endtask

    initial begin
        seed = 87;
        model_hist[0] = 8'd0;
        model_hist[1] = 8'd0;
        model_hist[2] = 8'd0;
        model_count = 16'd0;
        rst_n_buf1 = 1'b0;
        aw = '0;
        awvalid = 1'b0;
        w = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        ar = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        repeat (4) @(posedge clk_buf2);
        rst_n_buf1 <= 1'b1;
        verify_reset_state();
        run_restart_sample();
        stream_majority_values();
        fill_and_overflow();
        probe_decode_errors();
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* src/signal_recovery_top.sv */
// Top level of the recovery block that wires the AXI4-Lite slave, sample FIFO and majority voter
module signal_recovery_top #(
    parameter int unsigned depth = recovery_pkg::default_depth,
    localparam int unsigned level_w = $clog2(depth) + 1
) (
    input  logic                 clk_buf2,
    input  logic                 rst_n_buf1,
    input  axil_pkg::axil_aw_t   aw,
    input  logic                 awvalid,
    output logic                 awready,
    input  axil_pkg::axil_w_t    w,
    input  logic                 wvalid,
    output logic                 wready,
    output axil_pkg::axil_resp_t bresp,
    output logic                 bvalid,
    input  logic                 bready,
    input  axil_pkg::axil_ar_t   ar,
    input  logic                 arvalid,
    output logic                 arready,
    output axil_pkg::axil_r_t    r,
    output logic                 rvalid,
    input  logic                 rready
);

    logic                  push;
    recovery_pkg::sample_t push_item;
    logic                  pop;
    recovery_pkg::sample_t pop_item;
    logic                  full;
    logic                  empty;
    logic [level_w-1:0]    level;
    logic                  pause;
    recovery_pkg::result_t result;

    axil_reg_slave #(
        .depth (depth)
    ) i_axil_reg_slave (
        .clk_buf2   (clk_buf2),
        .rst_n_buf1 (rst_n_buf1),
        .aw         (aw),
        .awvalid    (awvalid),
        .awready    (awready),
        .w          (w),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .ar         (ar),
        .arvalid    (arvalid),
        .arready    (arready),
        .r          (r),
        .rvalid     (rvalid),
        .rready     (rready),
        .push       (push),
        .push_item  (push_item),
        .full       (full),
        .level      (level),
        .empty      (empty),
        .pause      (pause),
        .result     (result)
    );

    sample_fifo #(
        .depth  (depth),
        .item_t (recovery_pkg::sample_t)
    ) i_sample_fifo (
        .clk_buf2   (clk_buf2),
        .rst_n_buf1 (rst_n_buf1),
        .push       (push),
        .push_item  (push_item),
        .pop        (pop),
        .pop_item   (pop_item),
        .full       (full),
        .empty      (empty),
        .level      (level)
    );

    majority_recovery i_majority_recovery (
        .clk_buf2   (clk_buf2),
        .rst_n_buf1 (rst_n_buf1),
        .empty      (empty),
        .pause      (pause),
        .pop        (pop),
        .pop_item   (pop_item),
        .result     (result)
    );

endmodule

/* src/axil_reg_slave.sv */
// AXI4-Lite register slave that turns sample writes into FIFO pushes and answers status reads
module axil_reg_slave #(
    parameter int unsigned depth = recovery_pkg::default_depth,
    localparam int unsigned level_w = $clog2(depth) + 1
) (
    input  logic                  clk_buf2,
    input  logic                  rst_n_buf1,
    input  axil_pkg::axil_aw_t    aw,
    input  logic                  awvalid,
    output logic                  awready,
    input  axil_pkg::axil_w_t     w,
    input  logic                  wvalid,
    output logic                  wready,
    output axil_pkg::axil_resp_t  bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  axil_pkg::axil_ar_t    ar,
    input  logic                  arvalid,
    output logic                  arready,
    output axil_pkg::axil_r_t     r,
    output logic                  rvalid,
    input  logic                  rready,
    output logic                  push,
    output recovery_pkg::sample_t push_item,
    input  logic                  full,
    input  logic [level_w-1:0]    level,
    input  logic                  empty,
    output logic                  pause,
    input  recovery_pkg::result_t result
);

    logic [4:0]            waddr;
    logic [4:0]            raddr;
    logic                  write_go;
    logic                  read_go;
    logic                  read_take;
    recovery_pkg::status_t status;
    axil_pkg::axil_r_t     rd_word;

    assign waddr = aw.addr[4:0];
    assign raddr = ar.addr[4:0];

    // Both write channels present and no response outstanding
    assign write_go = awvalid && wvalid && !bvalid;

    always_ff @(posedge clk_buf2 or negedge rst_n_buf1) begin
        if (!rst_n_buf1) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= axil_pkg::resp_okay;
            push    <= 1'b0;
            pause   <= 1'b0;
        end else begin
            awready <= write_go;
            wready  <= write_go;
            push    <= 1'b0;
            if (write_go) begin
                bvalid <= 1'b1;
                bresp  <= axil_pkg::resp_okay;
                case (waddr)
                    recovery_pkg::addr_sample: begin
                        if (w.strb[0]) begin
                            // Refuse the sample rather than overwrite
                            if (full) begin
                                bresp <= axil_pkg::resp_slverr;
                            end else begin
                                push <= 1'b1;
                            end
                        end
                    end
                    recovery_pkg::addr_control: begin
                        if (w.strb[0]) begin
                            pause <= w.data[0];
                        end
                    end
                    default: bresp <= axil_pkg::resp_slverr;
                endcase
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // Sample payload with restart taken from byte 1
    always_ff @(posedge clk_buf2) begin
        if (write_go) begin
            push_item.value   <= w.data[7:0];
            push_item.restart <= w.data[8] & w.strb[1];
        end
    end

    // Pulse arready once, then capture data on the handshake edge
    assign read_go   = arvalid && !arready && !rvalid;
    assign read_take = arvalid && arready;

    always_ff @(posedge clk_buf2 or negedge rst_n_buf1) begin
        if (!rst_n_buf1) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= read_go;
            if (read_take) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        status          = '0;
        status.level    = 8'(level);
        status.full     = full;
        status.empty    = empty;
        rd_word.data    = '0;
        rd_word.resp    = axil_pkg::resp_okay;
        case (raddr)
            recovery_pkg::addr_sample:  rd_word.data = '0;
            recovery_pkg::addr_control: rd_word.data = {31'd0, pause};
            recovery_pkg::addr_clean:   rd_word.data = {24'd0, result.clean};
            recovery_pkg::addr_status:  rd_word.data = status;
            recovery_pkg::addr_count:   rd_word.data = {16'd0, result.count};
            default:                    rd_word.resp = axil_pkg::resp_slverr;
        endcase
    end

    always_ff @(posedge clk_buf2) begin
        if (read_take) begin
            r <= rd_word;
        end
    end

    a_bvalid_hold: assert property (@(posedge clk_buf2) disable iff (!rst_n_buf1)
        bvalid && !bready |=> bvalid);

    a_rvalid_hold: assert property (@(posedge clk_buf2) disable iff (!rst_n_buf1)
        rvalid && !rready |=> rvalid);

    // The full check is made a cycle before the push lands
    a_push_not_full: assert property (@(posedge clk_buf2) disable iff (!rst_n_buf1)
        push |-> !full);

endmodule

/* src/majority_recovery.sv */
// Consumer that drains the FIFO and votes each bit over the three newest samples
module majority_recovery (
    input  logic                  clk_buf2,
    input  logic                  rst_n_buf1,
    input  logic                  empty,
    input  logic                  pause,
    output logic                  pop,
    input  recovery_pkg::sample_t pop_item,
    output recovery_pkg::result_t result
);

    // hist[0] is the newest entry
    logic [7:0] hist [3];
    logic [7:0] next_hist [3];

    assign pop = !empty && !pause;

    always_comb begin
        if (pop_item.restart) begin
            next_hist[0] = pop_item.value;
            next_hist[1] = pop_item.value;
            next_hist[2] = pop_item.value;
        end else begin
            next_hist[0] = pop_item.value;
            next_hist[1] = hist[0];
            next_hist[2] = hist[1];
        end
    end

    always_ff @(posedge clk_buf2 or negedge rst_n_buf1) begin
        if (!rst_n_buf1) begin
            hist[0] <= '0;
            hist[1] <= '0;
            hist[2] <= '0;
            result  <= '0;
        end else if (pop) begin
            hist         <= next_hist;
            // Bitwise two-of-three vote
            result.clean <= (next_hist[0] & next_hist[1]) |
                            (next_hist[0] & next_hist[2]) |
                            (next_hist[1] & next_hist[2]);
            result.count <= result.count + 16'd1;
        end
    end

    a_pop_needs_data: assert property (@(posedge clk_buf2) disable iff (!rst_n_buf1)
        pop |-> !empty);

endmodule

/* src/sample_fifo.sv */
// Synchronous circular-buffer FIFO whose payload type is set by the instantiating module
module sample_fifo #(
    parameter int unsigned depth = recovery_pkg::default_depth,
    parameter type item_t = logic [7:0],
    localparam int unsigned ptr_w = $clog2(depth),
    localparam int unsigned level_w = ptr_w + 1
) (
    input  logic               clk_buf2,
    input  logic               rst_n_buf1,
    input  logic               push,
    input  item_t              push_item,
    input  logic               pop,
    output item_t              pop_item,
    output logic               full,
    output logic               empty,
    output logic [level_w-1:0] level
);

    item_t            mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;

    always_ff @(posedge clk_buf2) begin
        if (push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    // Pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk_buf2 or negedge rst_n_buf1) begin
        if (!rst_n_buf1) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // Head of queue straight from storage
    assign pop_item = mem[rd_ptr];
    assign full     = (level == level_w'(depth));
    assign empty    = (level == '0);

    a_no_overflow: assert property (@(posedge clk_buf2) disable iff (!rst_n_buf1)
        full |-> !push);

    a_no_underflow: assert property (@(posedge clk_buf2) disable iff (!rst_n_buf1)
        empty |-> !pop);

endmodule

/* src/recovery_pkg.sv */
// Register map, sample/result/status types and FIFO depth default for the recovery datapath
package recovery_pkg;

    localparam int unsigned default_depth = 8;

    // Byte offsets within the decoded addr[4:0]
    localparam logic [4:0] addr_sample  = 5'h00;
    localparam logic [4:0] addr_control = 5'h04;
    localparam logic [4:0] addr_clean   = 5'h08;
    localparam logic [4:0] addr_status  = 5'h0C;
    localparam logic [4:0] addr_count   = 5'h10;

    // Matches wdata[8:0] of a sample write
    typedef struct packed {
        logic       restart;
        logic [7:0] value;
    } sample_t;

    // Consumer output as seen by the slave
    typedef struct packed {
        logic [15:0] count;
        logic [7:0]  clean;
    } result_t;

    // STATUS register layout
    typedef struct packed {
        logic [21:0] reserved;
        logic        empty;
        logic        full;
        logic [7:0]  level;
    } status_t;

endpackage

/* src/axil_pkg.sv */
// AXI4-Lite channel payload types and response codes shared by the top level and the slave
package axil_pkg;

    // Write response travels as this bare code
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axil_resp_t;

    // Write address channel
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  prot;
    } axil_aw_t;

    // Write data channel
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axil_w_t;

    // Read address channel
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  prot;
    } axil_ar_t;

    // Read data channel
    typedef struct packed {
        logic [31:0] data;
        axil_resp_t  resp;
    } axil_r_t;

endpackage
